/* compile.f */
+incdir+test
logic/cpuPkg.sv
logic/instMem.sv
logic/regFile.sv
logic/decoder.sv
logic/alu.sv
logic/dataMem.sv
logic/singleCpu.sv
test/cpuTb.sv

/* run.sh */
#!/bin/sh
# Builds the processor testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module cpuTb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/VcpuTb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

/* test/isaModel.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Architectural state of the reference model
logic [31:0] archRegs [32];
logic [31:0] archMem [cpuPkg::dmemWords];
logic [31:0] archPc;

localparam logic [31:0] pcWrap = 32'(cpuPkg::imemWords * 4 - 1); // pc wraps inside imem

task automatic resetArch();
    for (int i = 0; i < 32; i++) begin
        archRegs[i] = '0;
    end
    for (int i = 0; i < cpuPkg::dmemWords; i++) begin
        archMem[i] = '0;
    end
    archPc = '0;
endtask

// Executes one instruction and reports what it did
task automatic stepArch(input logic [31:0] inst, output cpuPkg::retireT eff);
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] operand;
    logic [31:0] result;
    logic [31:0] target;
    logic signed [31:0] sA;
    logic signed [31:0] sB;
    logic [4:0] shift;
    logic [2:0] funct3;
    logic isReg;

    src1 = archRegs[inst[19:15]];
    src2 = archRegs[inst[24:20]];
    funct3 = inst[14:12];
    isReg = (inst[6:0] == cpuPkg::opR);
    target = archPc + 32'd4;
    result = '0;
    eff = '0;
    eff.pc = archPc;
    eff.rd = inst[11:7];
    eff.memWdata = src2; // rs2 field read even when it is immediate bits

    case (inst[6:0])
        cpuPkg::opR, cpuPkg::opImm: begin
            operand = isReg ? src2 : {{20{inst[31]}}, inst[31:20]};
            sA = src1;
            sB = operand;
            shift = operand[4:0];
            eff.regWe = 1'b1;
            case (funct3)
                3'b000: begin
                    if (isReg && inst[30]) begin
                        result = src1 - operand;
                    end else begin
                        result = src1 + operand;
                    end
                end
                3'b001: result = src1 << shift;
                3'b010: result = (sA < sB) ? 32'd1 : 32'd0;
                3'b100: result = src1 ^ operand;
                3'b101: begin
                    if (inst[30]) begin
                        result = sA >>> shift;
                    end else begin
                        result = src1 >> shift;
                    end
                end
                3'b110: result = src1 | operand;
                default: result = src1 & operand;
            endcase
        end
        cpuPkg::opLoad: begin
            eff.regWe = 1'b1;
            result = src1 + {{20{inst[31]}}, inst[31:20]};
        end
        cpuPkg::opStore: begin
            eff.memWe = 1'b1;
            result = src1 + {{20{inst[31]}}, inst[31:25], inst[11:7]};
            archMem[result[cpuPkg::dmemAddrW+1:2]] = src2;
        end
        cpuPkg::opBranch: begin
            result = src1 - src2;
            if ((funct3 == cpuPkg::f3Bne) != (src1 == src2)) begin
                target = archPc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
        end
        cpuPkg::opLui: begin
            eff.regWe = 1'b1;
            result = {inst[31:12], 12'b0};
        end
        default: begin
            result = '0;
        end
    endcase

    eff.memAddr = result;
    eff.wdata = result;
    if (inst[6:0] == cpuPkg::opLoad) begin
        eff.wdata = archMem[result[cpuPkg::dmemAddrW+1:2]];
    end
    if (eff.regWe && eff.rd != 5'd0) begin
        archRegs[eff.rd] = eff.wdata;
    end
    archPc = target & pcWrap;
endtask

`endif

/* test/cpuTb.sv */
module cpuTb;

    localparam int clkPeriod = 8;
    localparam int resetCycles = 5;
    localparam int progLen = 48;
    localparam int runCycles = 200;
    localparam int watchCycles = resetCycles + progLen + runCycles + 50;

    logic CLK;
    logic RST;
    logic run;
    logic loadWe;
    logic [cpuPkg::imemAddrW-1:0] loadAddr;
    logic [cpuPkg::xlen-1:0] loadData;
    logic retireValid;
    cpuPkg::retireT retire;
    logic [cpuPkg::xlen-1:0] pc;

    logic [31:0] progMem [cpuPkg::imemWords]; // Copy of what the imem should hold
    cpuPkg::retireT expected;
    int seed;

    `include "isaModel.svh"

    singleCpu dut (
        .CLK(CLK),
        .RST(RST),
        .run(run),
        .loadWe(loadWe),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .retireValid(retireValid),
        .retire(retire),
        .pc(pc)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #(clkPeriod / 2) CLK = ~CLK;
        end
    end

    function automatic int pick(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        if (got !== want) begin
            $display("mismatch %s: got %h expected %h", name, got, want);
            $display("Checks failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // RV32I encoders
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, cpuPkg::opR};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, cpuPkg::f3Sw, imm[4:0], cpuPkg::opStore};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], cpuPkg::opBranch};
    endfunction

    task automatic buildProgram();
        int kind;
        int hop;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [6:0] f7;
        logic [2:0] f3;
        for (int i = 0; i < cpuPkg::imemWords; i++) begin
            progMem[i] = cpuPkg::nopWord;
        end
        for (int i = 0; i < progLen; i++) begin
            kind = pick(10);
            rd = 5'(pick(8)); // x0 included on purpose
            rs1 = 5'(pick(8));
            rs2 = 5'(pick(8));
            f7 = 7'h00;
            if (kind < 3) begin
                case (pick(9))
                    0: f3 = cpuPkg::f3AddSub;
                    1: begin
                        f3 = cpuPkg::f3AddSub;
                        f7 = 7'h20;
                    end
                    2: f3 = cpuPkg::f3And;
                    3: f3 = cpuPkg::f3Or;
                    4: f3 = cpuPkg::f3Xor;
                    5: f3 = cpuPkg::f3Slt;
                    6: f3 = cpuPkg::f3Sll;
                    7: f3 = cpuPkg::f3SrlSra;
                    default: begin
                        f3 = cpuPkg::f3SrlSra;
                        f7 = 7'h20;
                    end
                endcase
                progMem[i] = encR(f7, rs2, rs1, f3, rd);
            end else if (kind < 5) begin
                case (pick(5))
                    0: f3 = cpuPkg::f3AddSub;
                    1: f3 = cpuPkg::f3And;
                    2: f3 = cpuPkg::f3Or;
                    3: f3 = cpuPkg::f3Xor;
                    default: f3 = cpuPkg::f3Slt;
                endcase
                progMem[i] = encI(12'($random(seed)), rs1, f3, rd, cpuPkg::opImm);
            end else if (kind == 5) begin
                progMem[i] = {20'($random(seed)), rd, cpuPkg::opLui};
            end else if (kind == 6) begin
                progMem[i] = encS(12'(pick(16) * 4), rs2);
            end else if (kind == 7) begin
                progMem[i] = encI(12'(pick(16) * 4), 5'd0, cpuPkg::f3Lw, rd, cpuPkg::opLoad);
            end else begin
                hop = 1 + pick(4);
                if (i + hop > progLen - 1) begin
                    hop = progLen - 1 - i; // Keep the target inside the program
                end
                if (hop == 0) begin
                    progMem[i] = cpuPkg::nopWord;
                end else begin
                    f3 = (pick(2) != 0) ? cpuPkg::f3Bne : cpuPkg::f3Beq;
                    progMem[i] = encB(13'(hop * 4), rs2, rs1, f3);
                end
            end
        end
    endtask

    // Checks every cycle against the model
    always @(negedge CLK) begin
        if (!RST) begin
            checkValue("retireValid", {31'b0, retireValid}, {31'b0, run});
            checkValue("pc", pc, archPc);
            if (retireValid) begin
                stepArch(progMem[archPc[cpuPkg::imemAddrW+1:2]], expected);
                checkValue("retire.pc", retire.pc, expected.pc);
                checkValue("retire.regWe", {31'b0, retire.regWe}, {31'b0, expected.regWe});
                checkValue("retire.rd", {27'b0, retire.rd}, {27'b0, expected.rd});
                checkValue("retire.wdata", retire.wdata, expected.wdata);
                checkValue("retire.memWe", {31'b0, retire.memWe}, {31'b0, expected.memWe});
                checkValue("retire.memAddr", retire.memAddr, expected.memAddr);
                checkValue("retire.memWdata", retire.memWdata, expected.memWdata);
            end
        end
    end

    initial begin
        #(watchCycles * clkPeriod);
        $display("Timeout: the run did not finish in the expected time");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        RST = 1'b1;
        run = 1'b0;
        loadWe = 1'b0;
        loadAddr = '0;
        loadData = '0;
        seed = 27;
        buildProgram();
        resetArch();

        repeat (resetCycles) @(posedge CLK);
        RST <= 1'b0;

        for (int i = 0; i < progLen; i++) begin
            @(posedge CLK);
            loadWe <= 1'b1;
            loadAddr <= i[cpuPkg::imemAddrW-1:0];
            loadData <= progMem[i];
        end
        @(posedge CLK);
        loadWe <= 1'b0;
        run <= 1'b1;

        repeat (runCycles) @(posedge CLK);
        run <= 1'b0;
        repeat (2) @(posedge CLK);

        $display("All checks passed");
        $finish;
    end

endmodule

/* logic/singleCpu.sv */
module singleCpu (
    input  logic CLK,
    input  logic RST,
    input  logic run,
    input  logic loadWe,
    input  logic [cpuPkg::imemAddrW-1:0] loadAddr,
    input  logic [cpuPkg::xlen-1:0] loadData,
    output logic retireValid,
    output cpuPkg::retireT retire,
    output logic [cpuPkg::xlen-1:0] pc
);

    logic [cpuPkg::xlen-1:0] inst;
    cpuPkg::ctrlT ctrl;
    logic [cpuPkg::regAddrW-1:0] rs1;
    logic [cpuPkg::regAddrW-1:0] rs2;
    logic [cpuPkg::regAddrW-1:0] rd;
    logic [cpuPkg::xlen-1:0] rdata1;
    logic [cpuPkg::xlen-1:0] rdata2;
    logic [cpuPkg::xlen-1:0] aluB;
    logic [cpuPkg::xlen-1:0] aluResult;
    logic aluZero;
    logic [cpuPkg::xlen-1:0] memRdata;
    logic [cpuPkg::xlen-1:0] wbData;
    logic branchTaken;
    logic [cpuPkg::xlen-1:0] nextPc;

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd = inst[11:7];

    instMem imem (
        .CLK(CLK),
        .RST(RST),
        .we(loadWe && !run), // Loading only while halted
        .waddr(loadAddr),
        .wdata(loadData),
        .raddr(pc[cpuPkg::imemAddrW+1:2]),
        .rdata(inst)
    );

    decoder dec (
        .inst(inst),
        .ctrl(ctrl)
    );

    regFile regs (
        .CLK(CLK),
        .RST(RST),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd),
        .we(ctrl.regWe && run),
        .wdata(wbData),
        .rdata1(rdata1),
        .rdata2(rdata2)
    );

    assign aluB = ctrl.aluSrcImm ? ctrl.imm : rdata2;

    alu aluUnit (
        .a(rdata1),
        .b(aluB),
        .op(ctrl.aluOp),
        .result(aluResult),
        .zero(aluZero)
    );

    dataMem dmem (
        .CLK(CLK),
        .RST(RST),
        .we(ctrl.memWe && run),
        .addr(aluResult),
        .wdata(rdata2),
        .rdata(memRdata)
    );

    assign wbData = ctrl.memToReg ? memRdata : aluResult;

    // beq wants zero set and bne wants it clear
    assign branchTaken = ctrl.branch && (aluZero ^ ctrl.branchNe);
    assign nextPc = (branchTaken ? pc + ctrl.imm : pc + 'd4) & cpuPkg::pcMask;

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else if (run) begin
            pc <= nextPc;
        end
    end

    // One instruction retires in every running cycle
    assign retireValid = run;

    always_comb begin
        retire.pc = pc;
        retire.regWe = ctrl.regWe;
        retire.rd = rd;
        retire.wdata = wbData;
        retire.memWe = ctrl.memWe;
        retire.memAddr = aluResult;
        retire.memWdata = rdata2;
    end

endmodule

/* logic/dataMem.sv */
module dataMem (
    input  logic CLK,
    input  logic RST,
    input  logic we,
    input  logic [cpuPkg::xlen-1:0] addr,
    input  logic [cpuPkg::xlen-1:0] wdata,
    output logic [cpuPkg::xlen-1:0] rdata
);

    logic [cpuPkg::xlen-1:0] mem [cpuPkg::dmemWords];
    logic [cpuPkg::dmemAddrW-1:0] wordIdx;

    // Byte address to word index, upper bits alias
    assign wordIdx = addr[cpuPkg::dmemAddrW+1:2];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < cpuPkg::dmemWords; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[wordIdx] <= wdata;
        end
    end

    assign rdata = mem[wordIdx]; // Combinational load path

    // Only whole words are stored
    alignedStore: assert property (
        @(posedge CLK) disable iff (RST) we |-> (addr[1:0] == 2'b00)
    ) else $error("misaligned store to address %h", addr);

endmodule

/* logic/alu.sv */
module alu (
    input  logic [cpuPkg::xlen-1:0] a,
    input  logic [cpuPkg::xlen-1:0] b,
    input  cpuPkg::aluOpT op,
    output logic [cpuPkg::xlen-1:0] result,
    output logic zero
);

    logic [4:0] shamt;
    logic lessThan;

    assign shamt = b[4:0]; // Only the low five bits shift
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            cpuPkg::aluAdd: begin
                result = a + b;
            end
            cpuPkg::aluSub: begin
                result = a - b;
            end
            cpuPkg::aluAnd: begin
                result = a & b;
            end
            cpuPkg::aluOr: begin
                result = a | b;
            end
            cpuPkg::aluXor: begin
                result = a ^ b;
            end
            cpuPkg::aluSlt: begin
                result = {{(cpuPkg::xlen - 1){1'b0}}, lessThan};
            end
            cpuPkg::aluSll: begin
                result = a << shamt;
            end
            cpuPkg::aluSrl: begin
                result = a >> shamt;
            end
            cpuPkg::aluSra: begin
                result = $unsigned($signed(a) >>> shamt); // Keeps the sign bit
            end
            cpuPkg::aluPassB: begin
                result = b; // lui
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

/* logic/decoder.sv */
module decoder (
    input  logic [cpuPkg::xlen-1:0] inst,
    output cpuPkg::ctrlT ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic alt; // Bit 30 selects sub and sra
    logic [cpuPkg::xlen-1:0] immI;
    logic [cpuPkg::xlen-1:0] immS;
    logic [cpuPkg::xlen-1:0] immB;
    logic [cpuPkg::xlen-1:0] immU;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt = inst[30];

    // Immediate formats, all sign extended from bit 31
    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'b0};

    always_comb begin
        ctrl = '0; // Unknown encodings fall through as a nop
        ctrl.aluOp = cpuPkg::aluAdd;

        case (opcode)
            cpuPkg::opR: begin
                ctrl.regWe = 1'b1;
                case (funct3)
                    cpuPkg::f3AddSub: ctrl.aluOp = alt ? cpuPkg::aluSub : cpuPkg::aluAdd;
                    cpuPkg::f3Sll: ctrl.aluOp = cpuPkg::aluSll;
                    cpuPkg::f3Slt: ctrl.aluOp = cpuPkg::aluSlt;
                    cpuPkg::f3Xor: ctrl.aluOp = cpuPkg::aluXor;
                    cpuPkg::f3SrlSra: ctrl.aluOp = alt ? cpuPkg::aluSra : cpuPkg::aluSrl;
                    cpuPkg::f3Or: ctrl.aluOp = cpuPkg::aluOr;
                    cpuPkg::f3And: ctrl.aluOp = cpuPkg::aluAnd;
                    default: ctrl.regWe = 1'b0;
                endcase
            end

            cpuPkg::opImm: begin
                ctrl.regWe = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.imm = immI;
                case (funct3)
                    cpuPkg::f3AddSub: ctrl.aluOp = cpuPkg::aluAdd;
                    cpuPkg::f3Slt: ctrl.aluOp = cpuPkg::aluSlt;
                    cpuPkg::f3Xor: ctrl.aluOp = cpuPkg::aluXor;
                    cpuPkg::f3Or: ctrl.aluOp = cpuPkg::aluOr;
                    cpuPkg::f3And: ctrl.aluOp = cpuPkg::aluAnd;
                    default: begin
                        // Immediate shifts are outside the subset
                        ctrl.regWe = 1'b0;
                        ctrl.aluSrcImm = 1'b0;
                        ctrl.imm = '0;
                    end
                endcase
            end

            cpuPkg::opLoad: begin
                if (funct3 == cpuPkg::f3Lw) begin
                    ctrl.regWe = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.aluOp = cpuPkg::aluAdd; // Base plus offset
                    ctrl.imm = immI;
                end
            end

            cpuPkg::opStore: begin
                if (funct3 == cpuPkg::f3Sw) begin
                    ctrl.memWe = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.aluOp = cpuPkg::aluAdd;
                    ctrl.imm = immS;
                end
            end

            cpuPkg::opBranch: begin
                if (funct3 == cpuPkg::f3Beq || funct3 == cpuPkg::f3Bne) begin
                    ctrl.branch = 1'b1;
                    ctrl.branchNe = (funct3 == cpuPkg::f3Bne);
                    ctrl.aluOp = cpuPkg::aluSub; // Equality via zero flag
                    ctrl.imm = immB;
                end
            end

            cpuPkg::opLui: begin
                ctrl.regWe = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = cpuPkg::aluPassB;
                ctrl.imm = immU;
            end

            default: begin
                ctrl.regWe = 1'b0;
            end
        endcase
    end

endmodule

/* logic/regFile.sv */
module regFile (
    input  logic CLK,
    input  logic RST,
    input  logic [cpuPkg::regAddrW-1:0] rs1,
    input  logic [cpuPkg::regAddrW-1:0] rs2,
    input  logic [cpuPkg::regAddrW-1:0] rd,
    input  logic we,
    input  logic [cpuPkg::xlen-1:0] wdata,
    output logic [cpuPkg::xlen-1:0] rdata1,
    output logic [cpuPkg::xlen-1:0] rdata2
);

    localparam int regCount = 2 ** cpuPkg::regAddrW;

    logic [cpuPkg::xlen-1:0] regs [regCount];
    logic writeHit;

    assign writeHit = we && (rd != '0); // x0 is never written

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeHit) begin
            regs[rd] <= wdata;
        end
    end

    // Reads see the value from before this cycle's write
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    // x0 stays zero across every retired instruction
    zeroRegHeld: assert property (
        @(posedge CLK) disable iff (RST) regs[0] == '0
    ) else $error("register x0 holds a nonzero value");

endmodule

/* logic/instMem.sv */
module instMem (
    input  logic CLK,
    input  logic RST,
    input  logic we,
    input  logic [cpuPkg::imemAddrW-1:0] waddr,
    input  logic [cpuPkg::xlen-1:0] wdata,
    input  logic [cpuPkg::imemAddrW-1:0] raddr,
    output logic [cpuPkg::xlen-1:0] rdata
);

    logic [cpuPkg::xlen-1:0] mem [cpuPkg::imemWords];

    // Load port, every word starts out as a nop
    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < cpuPkg::imemWords; i++) begin
                mem[i] <= cpuPkg::nopWord;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr]; // Fetch is combinational

    // Program loading only starts once reset has been released
    loadAfterReset: assert property (
        @(posedge CLK) RST |-> !we
    ) else $error("instruction memory written during reset");

endmodule

/* logic/cpuPkg.sv */
package cpuPkg;

    // Datapath and memory sizes
    localparam int xlen = 32;
    localparam int regAddrW = 5;
    localparam int imemWords = 64;
    localparam int dmemWords = 64;
    localparam int imemAddrW = $clog2(imemWords);
    localparam int dmemAddrW = $clog2(dmemWords);

    localparam logic [xlen-1:0] pcMask = xlen'(imemWords * 4 - 1); // Byte span of imem

    // Major opcodes
    localparam logic [6:0] opR = 7'b0110011;
    localparam logic [6:0] opImm = 7'b0010011;
    localparam logic [6:0] opLoad = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLui = 7'b0110111;

    // Funct3 codes
    localparam logic [2:0] f3AddSub = 3'b000; // Also addi
    localparam logic [2:0] f3Sll = 3'b001;
    localparam logic [2:0] f3Slt = 3'b010; // Also slti
    localparam logic [2:0] f3Xor = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or = 3'b110;
    localparam logic [2:0] f3And = 3'b111;
    localparam logic [2:0] f3Lw = 3'b010;
    localparam logic [2:0] f3Sw = 3'b010;
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;

    localparam logic [xlen-1:0] nopWord = 32'h0000_0013; // addi x0, x0, 0

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluSra,
        aluPassB
    } aluOpT;

    // Decoded controls for one instruction
    typedef struct packed {
        logic regWe;
        logic aluSrcImm; // Second operand from imm
        logic memWe;
        logic memToReg;
        logic branch;
        logic branchNe; // bne rather than beq
        aluOpT aluOp;
        logic [xlen-1:0] imm;
    } ctrlT;

    // Architectural effects of one retired instruction
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic regWe;
        logic [regAddrW-1:0] rd;
        logic [xlen-1:0] wdata;
        logic memWe;
        logic [xlen-1:0] memAddr;
        logic [xlen-1:0] memWdata;
    } retireT;

endpackage
